/* Makefile */
# Verilator build and run for the SMBus mailbox testbench
TOP       ?= tb_smbus_mailbox
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
BUILD     ?= obj_dir
FILELIST  ?= vlog.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: TOP VERILATOR FLAGS BUILD FILELIST"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(BUILD)

/* design/mailbox_pkg.sv */
package mailbox_pkg;

    // Number of SMBus target ports sharing the register file
    localparam int NUM_PORTS = 3;

    // 7-bit target address answered by every port
    localparam logic [6:0] SMBUS_ADDR = 7'h55;

    localparam int REG_AW = 8;
    localparam int DATA_W = 8;

    // PEC polynomial x^8 + x^2 + x + 1
    localparam logic [7:0] CRC_POLY = 8'h07;

    // Conditioned bus state of one port, levels plus single-cycle event pulses
    typedef struct packed {
        logic scl;
        logic sda;
        logic start;
        logic stop;
        logic scl_rise;
        logic scl_fall;
    } smb_line_t;

    // Byte offered to the shared CRC engine
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } crc_byte_t;

    // Register write request from one SMBus port
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] idx;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic              read;
        logic              write;
        logic [REG_AW-1:0] idx;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

endpackage

/* design/mailbox_regfile.sv */
`timescale 1ns/1ps

module mailbox_regfile (
    input  logic                           clk,
    input  logic                           i_resetn,
    input  mailbox_pkg::host_req_t         i_host,
    input  mailbox_pkg::reg_wr_t           i_port_wr [mailbox_pkg::NUM_PORTS],
    output logic [mailbox_pkg::DATA_W-1:0] o_host_rdata,
    output logic                           o_host_rdata_valid
);

    logic [mailbox_pkg::DATA_W-1:0] mem [2**mailbox_pkg::REG_AW];
    logic                           wr_en;
    logic [mailbox_pkg::REG_AW-1:0] wr_idx;
    logic [mailbox_pkg::DATA_W-1:0] wr_data;

    // Host first, then the lowest port index. A port write that loses in the
    // same cycle is dropped, ports are expected to take turns on the bus
    always_comb begin
        wr_en   = i_host.write;
        wr_idx  = i_host.idx;
        wr_data = i_host.wdata;
        if (!i_host.write) begin
            for (int p = mailbox_pkg::NUM_PORTS - 1; p >= 0; p--) begin
                if (i_port_wr[p].valid) begin
                    wr_en   = 1'b1;
                    wr_idx  = i_port_wr[p].idx;
                    wr_data = i_port_wr[p].data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_resetn) begin
        if (!i_resetn) begin
            for (int i = 0; i < 2**mailbox_pkg::REG_AW; i++) begin
                mem[i] <= '0;
            end
            o_host_rdata       <= '0;
            o_host_rdata_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                mem[wr_idx] <= wr_data;
            end
            // A read in the same cycle as a write to that index sees the old byte
            o_host_rdata_valid <= i_host.read;
            if (i_host.read) begin
                o_host_rdata <= mem[i_host.idx];
            end
        end
    end

endmodule

/* design/pec_crc8.sv */
`timescale 1ns/1ps

module pec_crc8 (
    input  logic                   clk,
    input  logic                   i_resetn,
    input  mailbox_pkg::crc_byte_t i_byte [mailbox_pkg::NUM_PORTS],
    input  mailbox_pkg::smb_line_t i_line [mailbox_pkg::NUM_PORTS],
    output logic [7:0]             o_crc
);

    logic                           any_stop;
    logic                           any_valid;
    logic [mailbox_pkg::DATA_W-1:0] pick;

    // Folds one byte into the CRC, MSB first, one polynomial step per bit
    function automatic logic [7:0] crc8_fold(input logic [7:0] crc, input logic [7:0] din);
        logic [7:0] c;
        c = crc ^ din;
        for (int b = 0; b < 8; b++) begin
            c = c[7] ? ((c << 1) ^ mailbox_pkg::CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    // Scan from the top so that the lowest valid port ends up picked
    always_comb begin
        any_stop  = 1'b0;
        any_valid = 1'b0;
        pick      = '0;
        for (int p = mailbox_pkg::NUM_PORTS - 1; p >= 0; p--) begin
            any_stop = any_stop | i_line[p].stop;
            if (i_byte[p].valid) begin
                any_valid = 1'b1;
                pick      = i_byte[p].data;
            end
        end
    end

    // Shared between ports, only one of them may be mid-transaction at a time
    always_ff @(posedge clk or negedge i_resetn) begin
        if (!i_resetn) begin
            o_crc <= 8'd0;
        end else if (any_stop) begin
            o_crc <= 8'd0;
        end else if (any_valid) begin
            o_crc <= crc8_fold(o_crc, pick);
        end
    end

endmodule

/* design/smbus_mailbox.sv */
`timescale 1ns/1ps

module smbus_mailbox (
    input  logic                              clk,
    input  logic                              i_resetn,
    input  logic [mailbox_pkg::NUM_PORTS-1:0] i_scl,
    input  logic [mailbox_pkg::NUM_PORTS-1:0] i_sda,
    output logic [mailbox_pkg::NUM_PORTS-1:0] o_sda_oe,
    input  logic                              i_host_read,
    input  logic                              i_host_write,
    input  logic [mailbox_pkg::REG_AW-1:0]    i_host_addr,
    input  logic [mailbox_pkg::DATA_W-1:0]    i_host_wdata,
    output logic [mailbox_pkg::DATA_W-1:0]    o_host_rdata,
    output logic                              o_host_rdata_valid
);

    mailbox_pkg::smb_line_t smb_line [mailbox_pkg::NUM_PORTS];
    mailbox_pkg::crc_byte_t crc_byte [mailbox_pkg::NUM_PORTS];
    mailbox_pkg::reg_wr_t   port_wr  [mailbox_pkg::NUM_PORTS];
    mailbox_pkg::host_req_t host_req;
    logic [7:0]             crc;

    assign host_req = '{read:  i_host_read,
                        write: i_host_write,
                        idx:   i_host_addr,
                        wdata: i_host_wdata};

    smbus_pin_sync u_pin_sync (
        .clk      (clk),
        .i_resetn (i_resetn),
        .i_scl    (i_scl),
        .i_sda    (i_sda),
        .o_line   (smb_line)
    );

    // One Write Byte target per port, all answering the same address
    for (genvar i = 0; i < mailbox_pkg::NUM_PORTS; i++) begin : g_port
        smbus_target u_target (
            .clk        (clk),
            .i_resetn   (i_resetn),
            .i_line     (smb_line[i]),
            .i_crc      (crc),
            .o_sda_oe   (o_sda_oe[i]),
            .o_crc_byte (crc_byte[i]),
            .o_reg_wr   (port_wr[i])
        );
    end

    pec_crc8 u_pec_crc8 (
        .clk      (clk),
        .i_resetn (i_resetn),
        .i_byte   (crc_byte),
        .i_line   (smb_line),
        .o_crc    (crc)
    );

    mailbox_regfile u_regfile (
        .clk                (clk),
        .i_resetn           (i_resetn),
        .i_host             (host_req),
        .i_port_wr          (port_wr),
        .o_host_rdata       (o_host_rdata),
        .o_host_rdata_valid (o_host_rdata_valid)
    );

endmodule

/* design/smbus_pin_sync.sv */
`timescale 1ns/1ps

module smbus_pin_sync (
    input  logic                                   clk,
    input  logic                                   i_resetn,
    input  logic [mailbox_pkg::NUM_PORTS-1:0]      i_scl,
    input  logic [mailbox_pkg::NUM_PORTS-1:0]      i_sda,
    output mailbox_pkg::smb_line_t                 o_line [mailbox_pkg::NUM_PORTS]
);

    logic [mailbox_pkg::NUM_PORTS-1:0] scl_meta;
    logic [mailbox_pkg::NUM_PORTS-1:0] scl_sync;
    logic [mailbox_pkg::NUM_PORTS-1:0] sda_meta;
    logic [mailbox_pkg::NUM_PORTS-1:0] sda_sync;

    // Everything resets to the idle bus with both lines high, so the first
    // real edge after reset cannot look like a start or a stop
    always_ff @(posedge clk or negedge i_resetn) begin
        if (!i_resetn) begin
            scl_meta <= '1;
            scl_sync <= '1;
            sda_meta <= '1;
            sda_sync <= '1;
            for (int p = 0; p < mailbox_pkg::NUM_PORTS; p++) begin
                o_line[p] <= '{scl: 1'b1, sda: 1'b1, default: 1'b0};
            end
        end else begin
            scl_meta <= i_scl;
            scl_sync <= scl_meta;
            sda_meta <= i_sda;
            sda_sync <= sda_meta;
            // The output register doubles as the edge flop, its level is the previous sample
            for (int p = 0; p < mailbox_pkg::NUM_PORTS; p++) begin
                o_line[p].scl      <= scl_sync[p];
                o_line[p].sda      <= sda_sync[p];
                o_line[p].scl_rise <= scl_sync[p] & ~o_line[p].scl;
                o_line[p].scl_fall <= ~scl_sync[p] & o_line[p].scl;
                o_line[p].start    <= scl_sync[p] & o_line[p].scl & o_line[p].sda & ~sda_sync[p];
                o_line[p].stop     <= scl_sync[p] & o_line[p].scl & ~o_line[p].sda & sda_sync[p];
            end
        end
    end

endmodule

/* design/smbus_target.sv */
`timescale 1ns/1ps

module smbus_target (
    input  logic                   clk,
    input  logic                   i_resetn,
    input  mailbox_pkg::smb_line_t i_line,
    input  logic [7:0]             i_crc,
    output logic                   o_sda_oe,
    output mailbox_pkg::crc_byte_t o_crc_byte,
    output mailbox_pkg::reg_wr_t   o_reg_wr
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RX,
        ST_ACK_WAIT,
        ST_ACK,
        ST_IGNORE
    } state_t;

    state_t                         state;
    logic [2:0]                     bit_cnt;
    // Bytes accepted after the address byte, 0 to 3
    logic [1:0]                     byte_cnt;
    logic                           addr_done;
    logic                           crc_valid;
    logic                           wr_valid;
    logic [mailbox_pkg::DATA_W-1:0] shift_q;
    logic [mailbox_pkg::REG_AW-1:0] cmd_q;
    logic [mailbox_pkg::DATA_W-1:0] data_q;
    logic [mailbox_pkg::DATA_W-1:0] rx_byte;
    logic                           byte_done;
    logic                           accept;
    logic                           commit;

    assign rx_byte   = {shift_q[6:0], i_line.sda};
    assign byte_done = (state == ST_RX) && i_line.scl_rise && (bit_cnt == 3'd7);

    // Address byte must match with R/W at 0, later bytes are taken up to the PEC
    assign accept = addr_done ? (byte_cnt != 2'd3)
                              : (rx_byte == {mailbox_pkg::SMBUS_ADDR, 1'b0});

    // Plain Write Byte, or Write Byte with PEC whose running CRC came out zero.
    // The CRC engine clears one cycle after the stop, so i_crc still holds here
    assign commit = (state == ST_RX) &&
                    ((byte_cnt == 2'd2) || ((byte_cnt == 2'd3) && (i_crc == 8'd0)));

    always_ff @(posedge clk or negedge i_resetn) begin
        if (!i_resetn) begin
            state     <= ST_IDLE;
            bit_cnt   <= 3'd0;
            byte_cnt  <= 2'd0;
            addr_done <= 1'b0;
            o_sda_oe  <= 1'b0;
            crc_valid <= 1'b0;
            wr_valid  <= 1'b0;
        end else begin
            crc_valid <= 1'b0;
            wr_valid  <= 1'b0;
            if (i_line.start) begin
                // A repeated start also lands here and begins a fresh transaction
                state     <= ST_RX;
                bit_cnt   <= 3'd0;
                byte_cnt  <= 2'd0;
                addr_done <= 1'b0;
                o_sda_oe  <= 1'b0;
            end else if (i_line.stop) begin
                wr_valid <= commit;
                state    <= ST_IDLE;
                o_sda_oe <= 1'b0;
            end else begin
                case (state)
                    ST_RX: begin
                        if (i_line.scl_rise) begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                        if (byte_done) begin
                            if (accept) begin
                                crc_valid <= 1'b1;
                                state     <= ST_ACK_WAIT;
                                addr_done <= 1'b1;
                                if (addr_done) begin
                                    byte_cnt <= byte_cnt + 2'd1;
                                end
                            end else begin
                                // NACK by leaving SDA alone until the next start or stop
                                state <= ST_IGNORE;
                            end
                        end
                    end
                    ST_ACK_WAIT: begin
                        if (i_line.scl_fall) begin
                            o_sda_oe <= 1'b1;
                            state    <= ST_ACK;
                        end
                    end
                    ST_ACK: begin
                        if (i_line.scl_fall) begin
                            o_sda_oe <= 1'b0;
                            state    <= ST_RX;
                        end
                    end
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // Shift register and the captured command and data bytes
    always_ff @(posedge clk) begin
        if ((state == ST_RX) && i_line.scl_rise) begin
            shift_q <= rx_byte;
        end
        if (byte_done && addr_done && accept) begin
            if (byte_cnt == 2'd0) begin
                cmd_q <= rx_byte;
            end
            if (byte_cnt == 2'd1) begin
                data_q <= rx_byte;
            end
        end
    end

    // The shift register holds the completed byte until the ACK clock
    assign o_crc_byte = '{valid: crc_valid, data: shift_q};
    assign o_reg_wr   = '{valid: wr_valid, idx: cmd_q, data: data_q};

endmodule

/* dv/tb_smbus_mailbox.sv */
`timescale 1ns/1ps

module tb_smbus_mailbox;

    localparam int         NPORTS      = mailbox_pkg::NUM_PORTS;
    localparam logic [6:0] TARGET_ADDR = 7'h55;
    // Clock cycles per SCL phase. The low phase is split around the SDA change
    localparam int         PHASE       = 8;
    localparam int         HALF        = PHASE / 2;
    // A PEC write takes about 610 cycles and a plain write about 470, over 48 transactions
    localparam int         MAX_CYCLES  = 40000;

    logic              clk;
    logic              i_resetn;
    logic [NPORTS-1:0] scl_drv;
    logic [NPORTS-1:0] sda_drv;
    logic [NPORTS-1:0] sda_wire;
    logic [NPORTS-1:0] o_sda_oe;
    logic              i_host_read;
    logic              i_host_write;
    logic [7:0]        i_host_addr;
    logic [7:0]        i_host_wdata;
    logic [7:0]        o_host_rdata;
    logic              o_host_rdata_valid;

    logic [7:0]        ref_mem [256];
    logic [7:0]        exp_q [$];
    logic [7:0]        exp_data;
    logic              rd_last;
    int                errors;
    int                checks;
    int                cycles;
    integer            seed;
    logic [7:0]        idx;
    logic [7:0]        cmd;
    logic [7:0]        data;
    logic [7:0]        pec;
    logic [6:0]        bad_addr;

    // Open-drain SDA is low when the bus model or the target pulls it
    assign sda_wire = sda_drv & ~o_sda_oe;

    smbus_mailbox dut0 (
        .clk                (clk),
        .i_resetn           (i_resetn),
        .i_scl              (scl_drv),
        .i_sda              (sda_wire),
        .o_sda_oe           (o_sda_oe),
        .i_host_read        (i_host_read),
        .i_host_write       (i_host_write),
        .i_host_addr        (i_host_addr),
        .i_host_wdata       (i_host_wdata),
        .o_host_rdata       (o_host_rdata),
        .o_host_rdata_valid (o_host_rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // PEC by the SMBus rule as a bit-serial CRC-8 with polynomial 0x07 and a zero start
    function automatic logic [7:0] pec_ref(input logic [7:0] a, input logic [7:0] c,
                                           input logic [7:0] d);
        logic [23:0] msg;
        logic [7:0]  crc;
        logic        fb;
        msg = {a, c, d};
        crc = 8'h00;
        for (int i = 23; i >= 0; i--) begin
            fb  = crc[7] ^ msg[i];
            crc = {crc[6:0], 1'b0};
            if (fb) begin
                crc = crc ^ 8'h07;
            end
        end
        return crc;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Returns 10 ns after the n-th rising edge from now
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic host_write(input logic [7:0] a, input logic [7:0] d);
        i_host_write = 1'b1;
        i_host_addr  = a;
        i_host_wdata = d;
        wait_cycles(1);
        i_host_write = 1'b0;
        ref_mem[a]   = d;
    endtask

    task automatic host_read(input logic [7:0] a);
        exp_q.push_back(ref_mem[a]);
        i_host_read = 1'b1;
        i_host_addr = a;
        wait_cycles(1);
        i_host_read = 1'b0;
        wait_cycles(1);
    endtask

    // Every read strobe must give exactly one valid cycle one clock later
    always @(negedge clk) begin
        if (i_resetn) begin
            check_eq("o_host_rdata_valid", 32'(o_host_rdata_valid), 32'(rd_last));
            if (rd_last) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("read data arrived with no expected value queued at %0t", $time);
                end else begin
                    exp_data = exp_q.pop_front();
                    if (o_host_rdata_valid) begin
                        check_eq("o_host_rdata", 32'(o_host_rdata), 32'(exp_data));
                    end
                end
            end
        end
        rd_last = i_host_read;
    end

    task automatic bus_start(input int p);
        sda_drv[p] = 1'b0;
        wait_cycles(PHASE);
    endtask

    // Returns 8 cycles after the SDA rise of the stop
    task automatic bus_stop(input int p);
        scl_drv[p] = 1'b0;
        wait_cycles(HALF);
        sda_drv[p] = 1'b0;
        wait_cycles(HALF);
        scl_drv[p] = 1'b1;
        wait_cycles(PHASE);
        sda_drv[p] = 1'b1;
        wait_cycles(PHASE);
    endtask

    // Eight data bits MSB first, then the ACK clock with SDA released
    task automatic bus_byte(input int p, input logic [7:0] b, output logic ack);
        for (int i = 7; i >= 0; i--) begin
            scl_drv[p] = 1'b0;
            wait_cycles(HALF);
            sda_drv[p] = b[i];
            wait_cycles(HALF);
            scl_drv[p] = 1'b1;
            wait_cycles(PHASE);
        end
        scl_drv[p] = 1'b0;
        wait_cycles(HALF);
        sda_drv[p] = 1'b1;
        wait_cycles(HALF);
        scl_drv[p] = 1'b1;
        wait_cycles(HALF);
        ack = ~sda_wire[p];
        wait_cycles(HALF);
    endtask

    // Write Byte with an optional PEC. Only 0x55 with R/W at 0 gets its address ACKed
    task automatic smbus_write(input int p, input logic [7:0] addr_byte, input logic [7:0] c,
                               input logic [7:0] d, input logic use_pec, input logic [7:0] pv);
        logic ack;
        logic exp_ack;
        exp_ack = (addr_byte == {TARGET_ADDR, 1'b0});
        bus_start(p);
        bus_byte(p, addr_byte, ack);
        check_eq("address ack", 32'(ack), 32'(exp_ack));
        if (ack) begin
            bus_byte(p, c, ack);
            check_eq("command ack", 32'(ack), 32'd1);
            bus_byte(p, d, ack);
            check_eq("data ack", 32'(ack), 32'd1);
            if (use_pec) begin
                bus_byte(p, pv, ack);
                check_eq("pec ack", 32'(ack), 32'd1);
            end
        end
        bus_stop(p);
    endtask

    initial begin
        seed         = 32'h1f84;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        rd_last      = 1'b0;
        i_resetn     = 1'b0;
        scl_drv      = '1;
        sda_drv      = '1;
        i_host_read  = 1'b0;
        i_host_write = 1'b0;
        i_host_addr  = 8'h00;
        i_host_wdata = 8'h00;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 8'h00;
        end
        wait_cycles(16);
        i_resetn = 1'b1;
        wait_cycles(2);

        // Idle outputs and a cleared register file after reset
        check_eq("o_host_rdata_valid", 32'(o_host_rdata_valid), 32'd0);
        check_eq("o_sda_oe", 32'(o_sda_oe), 32'd0);
        for (int i = 0; i < 16; i++) begin
            idx = 8'($random(seed));
            host_read(idx);
        end

        for (int i = 0; i < 32; i++) begin
            idx  = 8'($random(seed));
            data = 8'($random(seed));
            host_write(idx, data);
            host_read(idx);
        end

        // Plain Write Byte on each port in turn
        for (int r = 0; r < 8; r++) begin
            for (int p = 0; p < NPORTS; p++) begin
                cmd  = 8'($random(seed));
                data = 8'($random(seed));
                smbus_write(p, {TARGET_ADDR, 1'b0}, cmd, data, 1'b0, 8'h00);
                ref_mem[cmd] = data;
                host_read(cmd);
            end
        end

        // A wrong address and a read request are both NACKed and write nothing
        for (int p = 0; p < NPORTS; p++) begin
            bad_addr = 7'($random(seed));
            if (bad_addr == TARGET_ADDR) begin
                bad_addr = bad_addr ^ 7'h01;
            end
            cmd  = 8'($random(seed));
            data = 8'($random(seed));
            smbus_write(p, {bad_addr, 1'b0}, cmd, data, 1'b0, 8'h00);
            host_read(cmd);
            smbus_write(p, {TARGET_ADDR, 1'b1}, cmd, data, 1'b0, 8'h00);
            host_read(cmd);
        end

        // A good PEC commits while the inverted PEC is ACKed but leaves the register alone
        for (int r = 0; r < 3; r++) begin
            for (int p = 0; p < NPORTS; p++) begin
                cmd  = 8'($random(seed));
                data = 8'($random(seed));
                pec  = pec_ref({TARGET_ADDR, 1'b0}, cmd, data);
                smbus_write(p, {TARGET_ADDR, 1'b0}, cmd, data, 1'b1, pec);
                ref_mem[cmd] = data;
                host_read(cmd);
                cmd  = 8'($random(seed));
                data = 8'($random(seed));
                pec  = pec_ref({TARGET_ADDR, 1'b0}, cmd, data);
                smbus_write(p, {TARGET_ADDR, 1'b0}, cmd, data, 1'b1, ~pec);
                host_read(cmd);
            end
        end

        wait_cycles(4);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/mailbox_pkg.sv
design/smbus_pin_sync.sv
design/smbus_target.sv
design/pec_crc8.sv
design/mailbox_regfile.sv
design/smbus_mailbox.sv
dv/tb_smbus_mailbox.sv
